//--- vc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory tile array shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package vc_pkg;

  // link and data widths
  localparam int vc_data_width   = 32;
  localparam int vc_sel_width    = 4;
  localparam int vc_x_cord_width = 4;
  localparam int vc_y_cord_width = 4;

  // address fields, top to bottom: opcode, y, word index
  localparam int vc_word_width = 8;
  localparam int vc_op_width   = 2;
  localparam int vc_addr_width = vc_op_width + vc_y_cord_width + vc_word_width;

  localparam int vc_y_lsb  = vc_word_width;
  localparam int vc_op_lsb = vc_word_width + vc_y_cord_width;

  // opcode carried in the top address bits
  typedef enum logic [vc_op_width-1:0] {
    op_load    = 2'd0,
    op_store   = 2'd1,
    op_amo_add = 2'd2
  } vc_op_e;

  // bank sequencing
  typedef enum logic [1:0] {
    bank_idle,
    bank_amo_write,
    bank_ack
  } vc_bank_state_e;

endpackage

`default_nettype wire

//--- vc_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile memory bank, Wishbone slave with
// load, byte-select store and atomic add
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vc_bank #(
  parameter int bank_words_p = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               stb_i,
  input  logic                               we_i,
  input  vc_pkg::vc_op_e                     op_i,
  input  logic [vc_pkg::vc_word_width-1:0]   idx_i,
  input  logic [vc_pkg::vc_data_width-1:0]   dat_i,
  input  logic [vc_pkg::vc_sel_width-1:0]    sel_i,
  output logic                               ack_o,
  output logic [vc_pkg::vc_data_width-1:0]   dat_o
);

  import vc_pkg::*;

  localparam int idx_width_lp = (bank_words_p > 1) ? $clog2(bank_words_p) : 1;
  localparam int byte_width_lp = vc_data_width / vc_sel_width;

  vc_bank_state_e state_r;
  vc_bank_state_e state_n;

  logic [vc_data_width-1:0] mem_r [bank_words_p];
  logic [idx_width_lp-1:0]  idx;
  logic                     start;
  logic                     is_store;
  logic                     is_amo;

  assign idx   = idx_i[idx_width_lp-1:0];
  assign start = (state_r == bank_idle) && stb_i;

  // writes need we_i, the opcode picks the kind
  assign is_store = we_i && (op_i == op_store);
  assign is_amo   = we_i && (op_i == op_amo_add);

  always_comb begin
    state_n = state_r;
    case (state_r)
      bank_idle: begin
        if (stb_i) begin
          state_n = is_amo ? bank_amo_write : bank_ack;
        end
      end
      bank_amo_write: state_n = bank_ack;
      bank_ack:       state_n = bank_idle;
      default:        state_n = bank_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= bank_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // old word, returned on load and amo and used as the add operand
  always_ff @(posedge clk_i) begin
    if (start) begin
      dat_o <= mem_r[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (start && is_store) begin
      for (int b = 0; b < vc_sel_width; b++) begin
        if (sel_i[b]) begin
          mem_r[idx][byte_width_lp*b +: byte_width_lp] <=
            dat_i[byte_width_lp*b +: byte_width_lp];
        end
      end
    end else if (state_r == bank_amo_write) begin
      // full word, sel_i ignored
      mem_r[idx] <= dat_o + dat_i;
    end
  end

  assign ack_o = (state_r == bank_ack);

endmodule

`default_nettype wire

//--- vc_link_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vertical link router, steers requests
// to the local bank or on to the south
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vc_link_router (
  // north side, from the master
  input  logic                               n_cyc_i,
  input  logic                               n_stb_i,
  input  logic                               n_we_i,
  input  logic [vc_pkg::vc_addr_width-1:0]   n_adr_i,
  input  logic [vc_pkg::vc_data_width-1:0]   n_dat_i,
  input  logic [vc_pkg::vc_sel_width-1:0]    n_sel_i,
  output logic                               n_ack_o,
  output logic [vc_pkg::vc_data_width-1:0]   n_dat_o,

  // south side, toward the next row
  output logic                               s_cyc_o,
  output logic                               s_stb_o,
  output logic                               s_we_o,
  output logic [vc_pkg::vc_addr_width-1:0]   s_adr_o,
  output logic [vc_pkg::vc_data_width-1:0]   s_dat_o,
  output logic [vc_pkg::vc_sel_width-1:0]    s_sel_o,
  input  logic                               s_ack_i,
  input  logic [vc_pkg::vc_data_width-1:0]   s_dat_i,

  // local bank
  output logic                               bank_stb_o,
  output vc_pkg::vc_op_e                     bank_op_o,
  output logic [vc_pkg::vc_word_width-1:0]   bank_idx_o,
  input  logic                               bank_ack_i,
  input  logic [vc_pkg::vc_data_width-1:0]   bank_dat_i,

  input  logic [vc_pkg::vc_y_cord_width-1:0] my_y_i
);

  import vc_pkg::*;

  logic [vc_y_cord_width-1:0] adr_y;
  logic [vc_op_width-1:0]     adr_op;
  logic                       hit;
  logic                       req;

  assign adr_y  = n_adr_i[vc_y_lsb +: vc_y_cord_width];
  assign adr_op = n_adr_i[vc_op_lsb +: vc_op_width];
  assign hit    = (adr_y == my_y_i);
  assign req    = n_cyc_i && n_stb_i;

  // bank side
  assign bank_stb_o = req && hit;
  assign bank_idx_o = n_adr_i[vc_word_width-1:0];

  // unused opcode code falls back to a plain load
  always_comb begin
    case (adr_op)
      op_store:   bank_op_o = op_store;
      op_amo_add: bank_op_o = op_amo_add;
      default:    bank_op_o = op_load;
    endcase
  end

  // south stays quiet while the bank owns the request
  assign s_cyc_o = n_cyc_i && !hit;
  assign s_stb_o = req && !hit;
  assign s_we_o  = n_we_i && !hit;
  assign s_adr_o = n_adr_i;
  assign s_dat_o = n_dat_i;
  assign s_sel_o = n_sel_i;

  // response back north from the active side
  assign n_ack_o = n_cyc_i && (hit ? bank_ack_i : s_ack_i);
  assign n_dat_o = hit ? bank_dat_i : s_dat_i;

endmodule

`default_nettype wire

//--- vc_tile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory tile with router, bank, reset
// and coordinate pipeline registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vc_tile #(
  parameter int bank_words_p = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  output logic                               rst_n_o,

  input  logic [vc_pkg::vc_x_cord_width-1:0] global_x_i,
  input  logic [vc_pkg::vc_y_cord_width-1:0] global_y_i,
  output logic [vc_pkg::vc_x_cord_width-1:0] global_x_o,
  output logic [vc_pkg::vc_y_cord_width-1:0] global_y_o,

  input  logic                               n_cyc_i,
  input  logic                               n_stb_i,
  input  logic                               n_we_i,
  input  logic [vc_pkg::vc_addr_width-1:0]   n_adr_i,
  input  logic [vc_pkg::vc_data_width-1:0]   n_dat_i,
  input  logic [vc_pkg::vc_sel_width-1:0]    n_sel_i,
  output logic                               n_ack_o,
  output logic [vc_pkg::vc_data_width-1:0]   n_dat_o,

  output logic                               s_cyc_o,
  output logic                               s_stb_o,
  output logic                               s_we_o,
  output logic [vc_pkg::vc_addr_width-1:0]   s_adr_o,
  output logic [vc_pkg::vc_data_width-1:0]   s_dat_o,
  output logic [vc_pkg::vc_sel_width-1:0]    s_sel_o,
  input  logic                               s_ack_i,
  input  logic [vc_pkg::vc_data_width-1:0]   s_dat_i
);

  import vc_pkg::*;

  logic                       rst_n_r;
  logic [vc_x_cord_width-1:0] x_r;
  logic [vc_y_cord_width-1:0] y_r;

  logic                       bank_stb;
  vc_op_e                     bank_op;
  logic [vc_word_width-1:0]   bank_idx;
  logic                       bank_ack;
  logic [vc_data_width-1:0]   bank_dat;

  // one stage of the reset chain, also this tile's own reset
  always_ff @(posedge clk_i) begin
    rst_n_r <= rst_n_i;
  end

  // coordinates, y steps by one per row
  always_ff @(posedge clk_i) begin
    x_r <= global_x_i;
    y_r <= global_y_i + 1'b1;
  end

  assign rst_n_o    = rst_n_r;
  assign global_x_o = x_r;
  assign global_y_o = y_r;

  vc_link_router i_vc_link_router (
    .n_cyc_i    (n_cyc_i),
    .n_stb_i    (n_stb_i),
    .n_we_i     (n_we_i),
    .n_adr_i    (n_adr_i),
    .n_dat_i    (n_dat_i),
    .n_sel_i    (n_sel_i),
    .n_ack_o    (n_ack_o),
    .n_dat_o    (n_dat_o),
    .s_cyc_o    (s_cyc_o),
    .s_stb_o    (s_stb_o),
    .s_we_o     (s_we_o),
    .s_adr_o    (s_adr_o),
    .s_dat_o    (s_dat_o),
    .s_sel_o    (s_sel_o),
    .s_ack_i    (s_ack_i),
    .s_dat_i    (s_dat_i),
    .bank_stb_o (bank_stb),
    .bank_op_o  (bank_op),
    .bank_idx_o (bank_idx),
    .bank_ack_i (bank_ack),
    .bank_dat_i (bank_dat),
    .my_y_i     (y_r)
  );

  vc_bank #(
    .bank_words_p (bank_words_p)
  ) i_vc_bank (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_r),
    .stb_i   (bank_stb),
    .we_i    (n_we_i),
    .op_i    (bank_op),
    .idx_i   (bank_idx),
    .dat_i   (n_dat_i),
    .sel_i   (n_sel_i),
    .ack_o   (bank_ack),
    .dat_o   (bank_dat)
  );

endmodule

`default_nettype wire

//--- vc_tile_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory tile array, rows of tiles
// chained north to south per column
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vc_tile_array #(
  parameter int num_rows_p   = 3,
  parameter int num_cols_p   = 2,
  parameter int bank_words_p = 16
) (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  output logic [num_cols_p-1:0]                              rst_n_o,

  input  logic [num_cols_p-1:0][vc_pkg::vc_x_cord_width-1:0] global_x_i,
  input  logic [num_cols_p-1:0][vc_pkg::vc_y_cord_width-1:0] global_y_i,
  output logic [num_cols_p-1:0][vc_pkg::vc_x_cord_width-1:0] global_x_o,
  output logic [num_cols_p-1:0][vc_pkg::vc_y_cord_width-1:0] global_y_o,

  input  logic [num_cols_p-1:0]                              wb_n_cyc_i,
  input  logic [num_cols_p-1:0]                              wb_n_stb_i,
  input  logic [num_cols_p-1:0]                              wb_n_we_i,
  input  logic [num_cols_p-1:0][vc_pkg::vc_addr_width-1:0]   wb_n_adr_i,
  input  logic [num_cols_p-1:0][vc_pkg::vc_data_width-1:0]   wb_n_dat_i,
  input  logic [num_cols_p-1:0][vc_pkg::vc_sel_width-1:0]    wb_n_sel_i,
  output logic [num_cols_p-1:0]                              wb_n_ack_o,
  output logic [num_cols_p-1:0][vc_pkg::vc_data_width-1:0]   wb_n_dat_o,

  output logic [num_cols_p-1:0]                              wb_s_cyc_o,
  output logic [num_cols_p-1:0]                              wb_s_stb_o,
  output logic [num_cols_p-1:0]                              wb_s_we_o,
  output logic [num_cols_p-1:0][vc_pkg::vc_addr_width-1:0]   wb_s_adr_o,
  output logic [num_cols_p-1:0][vc_pkg::vc_data_width-1:0]   wb_s_dat_o,
  output logic [num_cols_p-1:0][vc_pkg::vc_sel_width-1:0]    wb_s_sel_o,
  input  logic [num_cols_p-1:0]                              wb_s_ack_i,
  input  logic [num_cols_p-1:0][vc_pkg::vc_data_width-1:0]   wb_s_dat_i
);

  import vc_pkg::*;

  // index r is the north side of row r, num_rows_p is the south edge
  logic [num_rows_p:0][num_cols_p-1:0]                      rst_chain;
  logic [num_rows_p:0][num_cols_p-1:0][vc_x_cord_width-1:0] x_chain;
  logic [num_rows_p:0][num_cols_p-1:0][vc_y_cord_width-1:0] y_chain;

  logic [num_rows_p:0][num_cols_p-1:0]                      dn_cyc;
  logic [num_rows_p:0][num_cols_p-1:0]                      dn_stb;
  logic [num_rows_p:0][num_cols_p-1:0]                      dn_we;
  logic [num_rows_p:0][num_cols_p-1:0][vc_addr_width-1:0]   dn_adr;
  logic [num_rows_p:0][num_cols_p-1:0][vc_data_width-1:0]   dn_dat;
  logic [num_rows_p:0][num_cols_p-1:0][vc_sel_width-1:0]    dn_sel;
  logic [num_rows_p:0][num_cols_p-1:0]                      up_ack;
  logic [num_rows_p:0][num_cols_p-1:0][vc_data_width-1:0]   up_dat;

  // north edge
  assign rst_chain[0] = {num_cols_p{rst_n_i}};
  assign x_chain[0]   = global_x_i;
  assign y_chain[0]   = global_y_i;
  assign dn_cyc[0]    = wb_n_cyc_i;
  assign dn_stb[0]    = wb_n_stb_i;
  assign dn_we[0]     = wb_n_we_i;
  assign dn_adr[0]    = wb_n_adr_i;
  assign dn_dat[0]    = wb_n_dat_i;
  assign dn_sel[0]    = wb_n_sel_i;
  assign wb_n_ack_o   = up_ack[0];
  assign wb_n_dat_o   = up_dat[0];

  // south edge
  assign rst_n_o             = rst_chain[num_rows_p];
  assign global_x_o          = x_chain[num_rows_p];
  assign global_y_o          = y_chain[num_rows_p];
  assign wb_s_cyc_o          = dn_cyc[num_rows_p];
  assign wb_s_stb_o          = dn_stb[num_rows_p];
  assign wb_s_we_o           = dn_we[num_rows_p];
  assign wb_s_adr_o          = dn_adr[num_rows_p];
  assign wb_s_dat_o          = dn_dat[num_rows_p];
  assign wb_s_sel_o          = dn_sel[num_rows_p];
  assign up_ack[num_rows_p]  = wb_s_ack_i;
  assign up_dat[num_rows_p]  = wb_s_dat_i;

  for (genvar r = 0; r < num_rows_p; r++) begin : g_row
    for (genvar c = 0; c < num_cols_p; c++) begin : g_col
      vc_tile #(
        .bank_words_p (bank_words_p)
      ) i_vc_tile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_chain[r][c]),
        .rst_n_o    (rst_chain[r+1][c]),
        .global_x_i (x_chain[r][c]),
        .global_y_i (y_chain[r][c]),
        .global_x_o (x_chain[r+1][c]),
        .global_y_o (y_chain[r+1][c]),
        .n_cyc_i    (dn_cyc[r][c]),
        .n_stb_i    (dn_stb[r][c]),
        .n_we_i     (dn_we[r][c]),
        .n_adr_i    (dn_adr[r][c]),
        .n_dat_i    (dn_dat[r][c]),
        .n_sel_i    (dn_sel[r][c]),
        .n_ack_o    (up_ack[r][c]),
        .n_dat_o    (up_dat[r][c]),
        .s_cyc_o    (dn_cyc[r+1][c]),
        .s_stb_o    (dn_stb[r+1][c]),
        .s_we_o     (dn_we[r+1][c]),
        .s_adr_o    (dn_adr[r+1][c]),
        .s_dat_o    (dn_dat[r+1][c]),
        .s_sel_o    (dn_sel[r+1][c]),
        .s_ack_i    (up_ack[r+1][c]),
        .s_dat_i    (up_dat[r+1][c])
      );
    end
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_p     = 100,
  parameter int rst_cycles_p = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // release on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (rst_cycles_p) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- vc_tile_array_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone edge checks for the tile array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vc_tile_array_sva #(
  parameter int num_rows_p = 3,
  parameter int num_cols_p = 2
) (
  input logic                                               clk_i,
  input logic [num_cols_p-1:0]                              rst_n_o,
  input logic [num_cols_p-1:0][vc_pkg::vc_y_cord_width-1:0] global_y_i,
  input logic [num_cols_p-1:0]                              wb_n_cyc_i,
  input logic [num_cols_p-1:0]                              wb_n_stb_i,
  input logic [num_cols_p-1:0]                              wb_n_we_i,
  input logic [num_cols_p-1:0][vc_pkg::vc_addr_width-1:0]   wb_n_adr_i,
  input logic [num_cols_p-1:0][vc_pkg::vc_data_width-1:0]   wb_n_dat_i,
  input logic [num_cols_p-1:0][vc_pkg::vc_sel_width-1:0]    wb_n_sel_i,
  input logic [num_cols_p-1:0]                              wb_n_ack_o,
  input logic [num_cols_p-1:0]                              wb_s_cyc_o,
  input logic [num_cols_p-1:0]                              wb_s_stb_o
);

  import vc_pkg::*;

  for (genvar c = 0; c < num_cols_p; c++) begin : g_col
    logic [vc_y_cord_width-1:0] y;
    logic                       hit;
    logic                       amo;
    int                         dy;

    assign y   = wb_n_adr_i[c][vc_y_lsb +: vc_y_cord_width];
    assign dy  = int'(y) - int'(global_y_i[c]);
    // rows sit at base y plus 1 .. num_rows_p
    assign hit = (dy >= 1) && (dy <= num_rows_p);
    assign amo = (wb_n_adr_i[c][vc_op_lsb +: vc_op_width] == op_amo_add);

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (!(&rst_n_o))
      wb_n_ack_o[c] |=> !wb_n_ack_o[c]) else $error("ack longer than one cycle");
    a_ack_req: assert property (@(posedge clk_i) disable iff (!(&rst_n_o))
      wb_n_ack_o[c] |-> wb_n_cyc_i[c] && wb_n_stb_i[c]) else $error("ack without request");
    a_lat_one: assert property (@(posedge clk_i) disable iff (!(&rst_n_o))
      $rose(wb_n_stb_i[c]) && wb_n_cyc_i[c] && hit && !amo |=> wb_n_ack_o[c])
      else $error("load or store latency wrong");
    a_lat_two: assert property (@(posedge clk_i) disable iff (!(&rst_n_o))
      $rose(wb_n_stb_i[c]) && wb_n_cyc_i[c] && hit && amo |=> !wb_n_ack_o[c] ##1 wb_n_ack_o[c])
      else $error("atomic add latency wrong");
    a_stable: assert property (@(posedge clk_i) disable iff (!(&rst_n_o))
      wb_n_cyc_i[c] && wb_n_stb_i[c] && !wb_n_ack_o[c] |=>
        $stable(wb_n_adr_i[c]) && $stable(wb_n_dat_i[c]) &&
        $stable(wb_n_sel_i[c]) && $stable(wb_n_we_i[c]))
      else $error("request changed before ack");
    a_south_quiet: assert property (@(posedge clk_i) disable iff (!(&rst_n_o))
      wb_n_cyc_i[c] && hit |-> !wb_s_cyc_o[c] && !wb_s_stb_o[c])
      else $error("south port active for an in-range request");
  end

endmodule

bind vc_tile_array vc_tile_array_sva #(
  .num_rows_p (num_rows_p),
  .num_cols_p (num_cols_p)
) i_vc_tile_array_sva (
  .clk_i      (clk_i),
  .rst_n_o    (rst_n_o),
  .global_y_i (global_y_i),
  .wb_n_cyc_i (wb_n_cyc_i),
  .wb_n_stb_i (wb_n_stb_i),
  .wb_n_we_i  (wb_n_we_i),
  .wb_n_adr_i (wb_n_adr_i),
  .wb_n_dat_i (wb_n_dat_i),
  .wb_n_sel_i (wb_n_sel_i),
  .wb_n_ack_o (wb_n_ack_o),
  .wb_s_cyc_o (wb_s_cyc_o),
  .wb_s_stb_o (wb_s_stb_o)
);

`default_nettype wire

//--- vc_tile_array_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile array testbench with south responder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vc_tile_array_tb;

  import vc_pkg::*;

  localparam int rows_lp  = 3;
  localparam int cols_lp  = 2;
  localparam int words_lp = 16;
  localparam int tests_lp = 6;

  logic clk;
  logic rst_n;
  logic [cols_lp-1:0]       rst_n_out;
  logic [cols_lp-1:0][3:0]  gx_i;
  logic [cols_lp-1:0][3:0]  gy_i;
  logic [cols_lp-1:0][3:0]  gx_o;
  logic [cols_lp-1:0][3:0]  gy_o;
  logic [cols_lp-1:0]       n_cyc, n_stb, n_we, n_ack;
  logic [cols_lp-1:0][13:0] n_adr;
  logic [cols_lp-1:0][31:0] n_dat, n_rdat;
  logic [cols_lp-1:0][3:0]  n_sel;
  logic [cols_lp-1:0]       s_cyc, s_stb, s_we, s_ack;
  logic [cols_lp-1:0][13:0] s_adr;
  logic [cols_lp-1:0][31:0] s_dat, s_rdat;
  logic [cols_lp-1:0][3:0]  s_sel;

  // what the responder saw on each south port
  logic [13:0] seen_adr [cols_lp];
  logic [31:0] seen_dat [cols_lp];
  logic [3:0]  seen_sel [cols_lp];
  logic        seen_we  [cols_lp];

  logic [31:0] model [cols_lp][rows_lp][words_lp];
  integer seed = 32'h71cc966b;
  int errors = 0;

  tb_clk_gen #(.period_p(100), .rst_cycles_p(3)) i_tb_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  vc_tile_array #(
    .num_rows_p (rows_lp), .num_cols_p (cols_lp), .bank_words_p (words_lp)
  ) i_vc_tile_array (
    .clk_i (clk), .rst_n_i (rst_n), .rst_n_o (rst_n_out),
    .global_x_i (gx_i), .global_y_i (gy_i), .global_x_o (gx_o), .global_y_o (gy_o),
    .wb_n_cyc_i (n_cyc), .wb_n_stb_i (n_stb), .wb_n_we_i (n_we), .wb_n_adr_i (n_adr),
    .wb_n_dat_i (n_dat), .wb_n_sel_i (n_sel), .wb_n_ack_o (n_ack), .wb_n_dat_o (n_rdat),
    .wb_s_cyc_o (s_cyc), .wb_s_stb_o (s_stb), .wb_s_we_o (s_we), .wb_s_adr_o (s_adr),
    .wb_s_dat_o (s_dat), .wb_s_sel_o (s_sel), .wb_s_ack_i (s_ack), .wb_s_dat_i (s_rdat)
  );

  // base y of 2 puts row r at y 3 + r
  function automatic logic [3:0] row_y(input int r);
    return 4'(3 + r);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, new_w,
                                              input logic [3:0] sel);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
  endtask

  // one Wishbone classic transfer with ack sampled on the rising edge
  task automatic xfer(input int c, input vc_op_e op, input logic [3:0] y,
                      input logic [7:0] idx, input logic [31:0] wd,
                      input logic [3:0] sel, output logic [31:0] rd);
    @(negedge clk);
    n_cyc[c] = 1'b1;
    n_stb[c] = 1'b1;
    n_we[c]  = (op != op_load);
    n_adr[c] = {op, y, idx};
    n_dat[c] = wd;
    n_sel[c] = sel;
    do @(posedge clk); while (!n_ack[c]);
    rd = n_rdat[c];
    @(negedge clk);
    n_cyc[c] = 1'b0;
    n_stb[c] = 1'b0;
    n_we[c]  = 1'b0;
  endtask

  task automatic respond(input int c);
    int dly;
    forever begin
      do @(posedge clk); while (!(s_cyc[c] && s_stb[c]));
      seen_adr[c] = s_adr[c];
      seen_dat[c] = s_dat[c];
      seen_sel[c] = s_sel[c];
      seen_we[c]  = s_we[c];
      dly = 1 + ($unsigned($random(seed)) % 4);
      repeat (dly - 1) @(posedge clk);
      @(negedge clk);
      s_ack[c]  = 1'b1;
      s_rdat[c] = {18'h0, s_adr[c]} ^ 32'h5a5a5a5a;
      @(negedge clk);
      s_ack[c]  = 1'b0;
    end
  endtask

  initial begin
    n_cyc  = '0;
    n_stb  = '0;
    n_we   = '0;
    n_adr  = '0;
    n_dat  = '0;
    n_sel  = '0;
    s_ack  = '0;
    s_rdat = '0;
    for (int c = 0; c < cols_lp; c++) begin
      gx_i[c] = 4'(c);
      gy_i[c] = 4'd2;
    end
    fork
      respond(0);
      respond(1);
    join
  end

  initial begin
    repeat (tests_lp * 200) @(posedge clk);
    $display("watchdog: tests did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] rd, wd, rd0, rd1, exp;
    logic [3:0]  sel;
    int e0;

    // reset chain takes one cycle per row
    e0 = errors;
    @(posedge rst_n);
    repeat (rows_lp - 1) @(negedge clk);
    check("reset_early", 32'(2'b00), 32'(rst_n_out));
    @(negedge clk);
    check("reset_late", 32'(2'b11), 32'(rst_n_out));
    for (int c = 0; c < cols_lp; c++) begin
      check("coord_x", 32'(c), 32'(gx_o[c]));
      check("coord_y", 32'(2 + rows_lp), 32'(gy_o[c]));
    end
    end_test("reset_coords", e0);

    e0 = errors;
    for (int c = 0; c < cols_lp; c++)
      for (int r = 0; r < rows_lp; r++)
        for (int i = 0; i < words_lp; i++) begin
          wd = $random(seed);
          xfer(c, op_store, row_y(r), 8'(i), wd, 4'hf, rd);
          model[c][r][i] = wd;
        end
    for (int c = 0; c < cols_lp; c++)
      for (int r = 0; r < rows_lp; r++)
        for (int i = 0; i < words_lp; i++) begin
          xfer(c, op_load, row_y(r), 8'(i), 32'h0, 4'hf, rd);
          check("store_load", model[c][r][i], rd);
        end
    end_test("store_load", e0);

    e0 = errors;
    for (int r = 0; r < rows_lp; r++) begin
      wd  = $random(seed);
      sel = 4'($random(seed));
      xfer(1, op_store, row_y(r), 8'd2, wd, sel, rd);
      model[1][r][2] = merge_bytes(model[1][r][2], wd, sel);
      xfer(1, op_load, row_y(r), 8'd2, 32'h0, 4'hf, rd);
      check("byte_select", model[1][r][2], rd);
    end
    end_test("byte_select", e0);

    e0 = errors;
    for (int r = 0; r < rows_lp; r++) begin
      wd = $random(seed);
      xfer(0, op_amo_add, row_y(r), 8'd1, wd, 4'h0, rd);
      check("amo_old", model[0][r][1], rd);
      model[0][r][1] = model[0][r][1] + wd;
      xfer(0, op_load, row_y(r), 8'd1, 32'h0, 4'hf, rd);
      check("amo_sum", model[0][r][1], rd);
    end
    end_test("atomic_add", e0);

    e0 = errors;
    wd = $random(seed);
    xfer(0, op_store, 4'd7, 8'd3, wd, 4'h5, rd);
    check("south_reply", {18'h0, op_store, 4'd7, 8'd3} ^ 32'h5a5a5a5a, rd);
    check("south_adr", 32'({op_store, 4'd7, 8'd3}), 32'(seen_adr[0]));
    check("south_dat", wd, seen_dat[0]);
    check("south_sel", 32'h5, 32'(seen_sel[0]));
    check("south_we", 32'h1, 32'(seen_we[0]));
    for (int c = 0; c < cols_lp; c++)
      for (int r = 0; r < rows_lp; r++)
        for (int i = 0; i < words_lp; i++) begin
          xfer(c, op_load, row_y(r), 8'(i), 32'h0, 4'hf, rd);
          check("south_no_change", model[c][r][i], rd);
        end
    end_test("south_forward", e0);

    e0 = errors;
    wd = $random(seed);
    exp = model[1][2][0];
    fork
      xfer(0, op_store, row_y(0), 8'd0, wd, 4'hf, rd0);
      xfer(1, op_load, row_y(2), 8'd0, 32'h0, 4'hf, rd1);
    join
    model[0][0][0] = wd;
    check("both_cols_load", exp, rd1);
    fork
      xfer(0, op_load, row_y(0), 8'd0, 32'h0, 4'hf, rd0);
      xfer(1, op_load, 4'd9, 8'd0, 32'h0, 4'hf, rd1);
    join
    check("both_cols_col0", model[0][0][0], rd0);
    check("both_cols_col1", {18'h0, op_load, 4'd9, 8'd0} ^ 32'h5a5a5a5a, rd1);
    end_test("both_columns", e0);

    $display("tests %0d, errors %0d", tests_lp, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vc_tile_array.f
vc_pkg.sv
vc_bank.sv
vc_link_router.sv
vc_tile.sv
vc_tile_array.sv
tb_clk_gen.sv
vc_tile_array_sva.sv
vc_tile_array_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tile array testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module vc_tile_array_tb \
  -f vc_tile_array.f \
  -o vc_sim

./obj_dir/vc_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0
